/* rtl/icache_params.svh */
/*
  Geometry of the direct-mapped instruction cache and its refill bus.
  Derived widths are written out by hand and must be kept consistent
  with the base values: 32-bit addresses, 128-bit lines, 64-bit beats.
*/
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Byte address width on both sides
`define ICACHE_ADDR_W   32
// One cache line
`define ICACHE_LINE_W   128
// One refill beat
`define ICACHE_BUS_W    64
`define ICACHE_SETS     64

// Derived from the values above
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W  6
`define ICACHE_TAG_W    22
`define ICACHE_BEATS    2
// Burst length is beats minus one
`define ICACHE_BLEN_W   1

`endif

/* rtl/icache_pkg.sv */
/*
  Cache-side types: fetch address, instruction word, line, tag and index.
  Instructions are fixed at 32 bits and fetch addresses are word aligned.
*/
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  // Byte address of a fetch
  typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;

  // One instruction word, four per line
  typedef logic [31:0] instr_t;

  // Whole line as held in the data array
  typedef logic [`ICACHE_LINE_W-1:0] line_t;

  // Address split into tag | index | offset
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // Lookup FSM
  // IDLE accepts, COMPARE checks the arrays,
  // REFILL_WAIT waits for the bus, RESPOND answers
  typedef enum logic [1:0] {
    IDLE,
    COMPARE,
    REFILL_WAIT,
    RESPOND
  } lookup_state_t;

endpackage

`default_nettype wire

/* rtl/rd_bus_pkg.sv */
/*
  Refill bus types. One read is outstanding at a time, so the bus
  carries no transaction ID; beat size is fixed at the bus width.
*/
`default_nettype none

`include "icache_params.svh"

package rd_bus_pkg;

  // Byte address presented with the request
  typedef logic [`ICACHE_ADDR_W-1:0] bus_addr_t;

  // One data beat
  typedef logic [`ICACHE_BUS_W-1:0] beat_t;

  // Number of beats minus one
  typedef logic [`ICACHE_BLEN_W-1:0] blen_t;

endpackage

`default_nettype wire

/* rtl/icache_lookup.sv */
/*
  Blocking direct-mapped lookup stage. One fetch is in flight at a time.
  Hits answer two cycles after acceptance; misses and bypasses wait for
  a full line or a single beat from the refill path. Bypass fetches
  (fetch_nc_i or en_i low) leave the arrays untouched.
*/
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_lookup (
  input  wire                      clk_i,
  input  wire                      rst_i,
  // Fetch request side
  input  wire                      fetch_req_i,
  input  icache_pkg::fetch_addr_t  fetch_addr_i,
  input  wire                      fetch_nc_i,
  input  wire                      en_i,
  input  wire                      flush_i,
  output logic                     fetch_ready_o,
  output logic                     fetch_valid_o,
  output icache_pkg::instr_t       fetch_data_o,
  output logic                     miss_o,
  // Line from the burst assembler
  input  wire                      line_valid_i,
  input  icache_pkg::line_t        line_data_i,
  // Refill request out
  output logic                     refill_start_o,
  output icache_pkg::fetch_addr_t  refill_addr_o,
  output logic                     refill_single_o
);

  icache_pkg::lookup_state_t state_q, state_d;

  // Accepted request
  icache_pkg::fetch_addr_t req_addr_q;
  logic                    req_bypass_q;

  // Arrays
  logic [`ICACHE_SETS-1:0] valid_q;
  icache_pkg::tag_t        tag_mem  [`ICACHE_SETS];
  icache_pkg::line_t       data_mem [`ICACHE_SETS];

  icache_pkg::index_t req_index;
  icache_pkg::tag_t   req_tag;
  icache_pkg::line_t  hit_line;
  logic               lookup_hit;
  logic [1:0]         word_sel;
  icache_pkg::instr_t rdata_q;

  // Address split
  assign req_index = req_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign req_tag   = req_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // Asynchronous array read at the registered index
  assign hit_line   = data_mem[req_index];
  // Bypass never hits
  assign lookup_hit = ~req_bypass_q & valid_q[req_index] & (tag_mem[req_index] == req_tag);

  // Word within the line; a bypass beat sits in the low 64 bits
  assign word_sel = req_bypass_q ? {1'b0, req_addr_q[2]} : req_addr_q[3:2];

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: begin
        if (fetch_req_i) begin
          state_d = icache_pkg::COMPARE;
        end
      end
      icache_pkg::COMPARE: begin
        if (lookup_hit) begin
          state_d = icache_pkg::RESPOND;
        end else begin
          state_d = icache_pkg::REFILL_WAIT;
        end
      end
      icache_pkg::REFILL_WAIT: begin
        // Slow beats simply keep us here
        if (line_valid_i) begin
          state_d = icache_pkg::RESPOND;
        end
      end
      icache_pkg::RESPOND: begin
        state_d = icache_pkg::IDLE;
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  // Control state and valid bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= icache_pkg::IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      // Flush only honoured while idle
      if ((state_q == icache_pkg::IDLE) && flush_i) begin
        valid_q <= '0;
      end
      if ((state_q == icache_pkg::REFILL_WAIT) && line_valid_i && !req_bypass_q) begin
        valid_q[req_index] <= 1'b1;
      end
    end
  end

  // Request capture, array fill and response word
  always_ff @(posedge clk_i) begin
    if ((state_q == icache_pkg::IDLE) && fetch_req_i) begin
      req_addr_q   <= fetch_addr_i;
      req_bypass_q <= fetch_nc_i | ~en_i;
    end
    if ((state_q == icache_pkg::REFILL_WAIT) && line_valid_i) begin
      // Cacheable miss fills the set
      if (!req_bypass_q) begin
        tag_mem[req_index]  <= req_tag;
        data_mem[req_index] <= line_data_i;
      end
      rdata_q <= line_data_i[{word_sel, 5'b0} +: 32];
    end
    if ((state_q == icache_pkg::COMPARE) && lookup_hit) begin
      rdata_q <= hit_line[{word_sel, 5'b0} +: 32];
    end
  end

  // Fetch side
  assign fetch_ready_o = (state_q == icache_pkg::IDLE);
  assign fetch_valid_o = (state_q == icache_pkg::RESPOND);
  assign fetch_data_o  = rdata_q;
  // Pulses for cacheable misses only
  assign miss_o        = (state_q == icache_pkg::COMPARE) & ~req_bypass_q & ~lookup_hit;

  // Refill kicks off in COMPARE in the same cycle as the miss
  assign refill_start_o  = (state_q == icache_pkg::COMPARE) & ~lookup_hit;
  assign refill_addr_o   = req_addr_q;
  assign refill_single_o = req_bypass_q;

endmodule

`default_nettype wire

/* rtl/refill_request.sv */
/*
  Holds a refill read until the bus grants it. The request is visible in
  the start cycle and a grant in that same cycle ends it at once.
  A new start must not arrive while a request is still pending.
*/
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module refill_request (
  input  wire                      clk_i,
  input  wire                      rst_i,
  // From lookup
  input  wire                      refill_start_i,
  input  icache_pkg::fetch_addr_t  refill_addr_i,
  input  wire                      refill_single_i,
  // Bus request side
  input  wire                      rd_gnt_i,
  output logic                     rd_req_o,
  output rd_bus_pkg::bus_addr_t    rd_addr_o,
  output rd_bus_pkg::blen_t        rd_blen_o
);

  logic pending_q;
  logic pending_d;

  // Request payload, held until granted
  icache_pkg::fetch_addr_t addr_q;
  icache_pkg::fetch_addr_t addr_d;
  logic                    single_q;
  logic                    single_d;

  // Stay pending until the grant cycle
  assign pending_d = ~rd_gnt_i & (refill_start_i | pending_q);

  // New request takes over the payload immediately
  assign addr_d   = refill_start_i ? refill_addr_i   : addr_q;
  assign single_d = refill_start_i ? refill_single_i : single_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q   <= addr_d;
    single_q <= single_d;
  end

  // Zero-cycle request out
  assign rd_req_o = refill_start_i | pending_q;

  // Bypass reads one beat, 8-byte aligned; refill reads a whole line
  assign rd_addr_o = single_d ?
                     {addr_d[`ICACHE_ADDR_W-1:3], 3'b000} :
                     {addr_d[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

  assign rd_blen_o = single_d ? '0 : rd_bus_pkg::blen_t'(`ICACHE_BEATS - 1);

endmodule

`default_nettype wire

/* rtl/burst_assembler.sv */
/*
  Builds a cache line from returning beats. Beats enter from the top;
  the first beat of each burst is also copied to offset 0, so a lone
  bypass beat ends up in the low half. Assumes line wider than a beat.
*/
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module burst_assembler (
  input  wire                clk_i,
  input  wire                rst_i,
  // Read data from the bus
  input  wire                rd_valid_i,
  input  wire                rd_last_i,
  input  rd_bus_pkg::beat_t  rd_data_i,
  // Assembled line to lookup
  output logic               line_valid_o,
  output icache_pkg::line_t  line_data_o
);

  icache_pkg::line_t shift_q;
  icache_pkg::line_t shift_d;

  // Marks the next beat as the start of a burst
  logic first_q;
  logic first_d;

  always_comb begin
    first_d = first_q;
    shift_d = shift_q;
    if (rd_valid_i) begin
      first_d = rd_last_i;
      // Shift down one beat, new beat on top
      shift_d = {rd_data_i, shift_q[`ICACHE_LINE_W-1:`ICACHE_BUS_W]};
      // Single-beat reply must land at offset 0
      if (first_q) begin
        shift_d[`ICACHE_BUS_W-1:0] = rd_data_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      first_q <= 1'b1;
    end else begin
      first_q <= first_d;
    end
  end

  // Line shift register
  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
  end

  // Line is handed over in the cycle of the last beat
  assign line_valid_o = rd_valid_i & rd_last_i;
  assign line_data_o  = shift_d;

endmodule

`default_nettype wire

/* rtl/icache_refill_top.sv */
/*
  Instruction cache with its burst refill port. Blocking, one fetch and
  one bus read at a time. Read data is always accepted by the cache,
  so the bus side has no ready signal.
*/
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_refill_top (
  input  wire                      clk_i,
  input  wire                      rst_i,
  // Fetch side
  input  wire                      fetch_req_i,
  input  icache_pkg::fetch_addr_t  fetch_addr_i,
  input  wire                      fetch_nc_i,
  input  wire                      en_i,
  input  wire                      flush_i,
  output logic                     fetch_ready_o,
  output logic                     fetch_valid_o,
  output icache_pkg::instr_t       fetch_data_o,
  output logic                     miss_o,
  // Refill bus
  output logic                     rd_req_o,
  input  wire                      rd_gnt_i,
  output rd_bus_pkg::bus_addr_t    rd_addr_o,
  output rd_bus_pkg::blen_t        rd_blen_o,
  input  wire                      rd_valid_i,
  input  wire                      rd_last_i,
  input  rd_bus_pkg::beat_t        rd_data_i
);

  // Lookup to request
  logic                    refill_start;
  icache_pkg::fetch_addr_t refill_addr;
  logic                    refill_single;

  // Assembler to lookup
  logic              line_valid;
  icache_pkg::line_t line_data;

  icache_lookup icache_lookup_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_nc_i      (fetch_nc_i),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .miss_o          (miss_o),
    .line_valid_i    (line_valid),
    .line_data_i     (line_data),
    .refill_start_o  (refill_start),
    .refill_addr_o   (refill_addr),
    .refill_single_o (refill_single)
  );

  refill_request refill_request_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .refill_start_i  (refill_start),
    .refill_addr_i   (refill_addr),
    .refill_single_i (refill_single),
    .rd_gnt_i        (rd_gnt_i),
    .rd_req_o        (rd_req_o),
    .rd_addr_o       (rd_addr_o),
    .rd_blen_o       (rd_blen_o)
  );

  burst_assembler burst_assembler_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rd_valid_i   (rd_valid_i),
    .rd_last_i    (rd_last_i),
    .rd_data_i    (rd_data_i),
    .line_valid_o (line_valid),
    .line_data_o  (line_data)
  );

endmodule

`default_nettype wire

/* bench/tb_icache_refill.sv */
/*
  Random testbench for the instruction cache with burst refill.
  One fetch at a time; the bus model grants and returns beats with
  random delays from a fixed xorshift seed. Expected words come from
  a mixing function of the 8-byte address; hit or miss from a tag model.
*/
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tb_icache_refill;

  localparam int WAIT_LIMIT = 50;

  logic                    clk_i;
  logic                    rst_i;
  logic                    fetch_req_i;
  icache_pkg::fetch_addr_t fetch_addr_i;
  logic                    fetch_nc_i;
  logic                    en_i;
  logic                    flush_i;
  logic                    fetch_ready_o;
  logic                    fetch_valid_o;
  icache_pkg::instr_t      fetch_data_o;
  logic                    miss_o;
  logic                    rd_req_o;
  logic                    rd_gnt_i;
  rd_bus_pkg::bus_addr_t   rd_addr_o;
  rd_bus_pkg::blen_t       rd_blen_o;
  logic                    rd_valid_i;
  logic                    rd_last_i;
  rd_bus_pkg::beat_t       rd_data_i;

  // Tag model of the cache
  logic             model_valid [`ICACHE_SETS];
  icache_pkg::tag_t model_tag   [`ICACHE_SETS];

  logic [31:0] rng_state;
  int checks;
  int errors;
  int hits;
  int misses;
  int bypasses;
  int tests_done;
  int test_errors;
  logic hung;

  icache_refill_top icache_refill_top_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_nc_i    (fetch_nc_i),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .miss_o        (miss_o),
    .rd_req_o      (rd_req_o),
    .rd_gnt_i      (rd_gnt_i),
    .rd_addr_o     (rd_addr_o),
    .rd_blen_o     (rd_blen_o),
    .rd_valid_i    (rd_valid_i),
    .rd_last_i     (rd_last_i),
    .rd_data_i     (rd_data_i)
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Memory contents as a fixed mix of the 8-byte beat address
  function automatic rd_bus_pkg::beat_t mem_beat(input rd_bus_pkg::bus_addr_t a);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = (a * 32'h2545_f491) ^ 32'h5a5a_c3c3;
    hi = (a * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    return {hi, lo};
  endfunction

  // Bit 2 of the byte address picks the word within its beat
  function automatic icache_pkg::instr_t expected_word(input icache_pkg::fetch_addr_t a);
    rd_bus_pkg::beat_t beat;
    beat = mem_beat({a[`ICACHE_ADDR_W-1:3], 3'b000});
    return a[2] ? beat[63:32] : beat[31:0];
  endfunction

  // Small pool of tags and sets so hits and conflicts both happen
  function automatic icache_pkg::fetch_addr_t random_addr();
    logic [31:0]        r;
    icache_pkg::tag_t   tag;
    icache_pkg::index_t idx;
    r   = next_random();
    tag = 22'h2b4c0 + (r[1:0] % 3);
    idx = (r[6:4] == 3'd0) ? 6'd63 : {4'b0000, r[3:2]};
    return {tag, idx, r[9:8], 2'b00};
  endfunction

  task automatic compare_instr(input string name, input icache_pkg::instr_t got,
                               input icache_pkg::instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_addr(input string name, input rd_bus_pkg::bus_addr_t got,
                              input rd_bus_pkg::bus_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_blen(input string name, input rd_bus_pkg::blen_t got,
                              input rd_bus_pkg::blen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  // Called at a falling edge; returns at a falling edge with ready high
  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!fetch_ready_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!fetch_ready_o) begin
      $display("Timeout: fetch_ready_o stayed low for %0d cycles", WAIT_LIMIT);
      hung = 1'b1;
    end
  endtask

  task automatic do_flush();
    if (hung) return;
    wait_ready();
    if (hung) return;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      model_valid[s] = 1'b0;
    end
  endtask

  // One fetch through the DUT with the bench as bus slave on a refill
  task automatic do_fetch(input icache_pkg::fetch_addr_t addr, input logic nc,
                          input logic en);
    logic                  bypass;
    logic                  exp_hit;
    icache_pkg::index_t    idx;
    icache_pkg::tag_t      tag;
    icache_pkg::instr_t    exp_word;
    rd_bus_pkg::bus_addr_t exp_addr;
    rd_bus_pkg::blen_t     exp_blen;
    rd_bus_pkg::bus_addr_t beat_addr;
    int beats;
    int gnt_delay;
    int gap;
    int waited;
    if (hung) return;
    bypass   = nc | ~en;
    idx      = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    tag      = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    exp_hit  = !bypass && model_valid[idx] && (model_tag[idx] == tag);
    exp_word = expected_word(addr);
    // Bypass reads one beat, a refill the whole line
    exp_addr = bypass ? {addr[`ICACHE_ADDR_W-1:3], 3'b000} :
                        {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], 4'b0000};
    exp_blen = bypass ? 1'b0 : 1'b1;
    beats    = bypass ? 1 : `ICACHE_BEATS;
    wait_ready();
    if (hung) return;
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    fetch_nc_i   = nc;
    en_i         = en;
    @(negedge clk_i);
    // Lookup is in COMPARE now; scramble the idle request inputs
    fetch_req_i  = 1'b0;
    fetch_addr_i = next_random();
    fetch_nc_i   = rng_state[3];
    en_i         = rng_state[7];
    compare_bit("fetch_ready_o", fetch_ready_o, 1'b0);
    compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    compare_bit("miss_o", miss_o, !bypass && !exp_hit);
    compare_bit("rd_req_o", rd_req_o, !exp_hit);
    if (exp_hit) begin
      // Fixed hit latency of two cycles
      @(negedge clk_i);
      compare_bit("fetch_valid_o", fetch_valid_o, 1'b1);
      compare_bit("miss_o", miss_o, 1'b0);
      compare_bit("rd_req_o", rd_req_o, 1'b0);
      compare_instr("fetch_data_o", fetch_data_o, exp_word);
      @(negedge clk_i);
      compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
      compare_bit("fetch_ready_o", fetch_ready_o, 1'b1);
      hits++;
      return;
    end
    // Request held with stable fields until granted
    gnt_delay = next_random() % 4;
    for (int k = 0; k <= gnt_delay; k++) begin
      if (k > 0) begin
        @(negedge clk_i);
        compare_bit("rd_req_o", rd_req_o, 1'b1);
      end
      compare_addr("rd_addr_o", rd_addr_o, exp_addr);
      compare_blen("rd_blen_o", rd_blen_o, exp_blen);
      compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    end
    rd_gnt_i = 1'b1;
    @(negedge clk_i);
    rd_gnt_i = 1'b0;
    compare_bit("rd_req_o", rd_req_o, 1'b0);
    compare_bit("miss_o", miss_o, 1'b0);
    // Beats in address order with random gaps between them
    for (int b = 0; b < beats; b++) begin
      gap = next_random() % 4;
      for (int k = 0; k < gap; k++) begin
        compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
        @(negedge clk_i);
      end
      compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
      beat_addr  = exp_addr + (b * 8);
      rd_valid_i = 1'b1;
      rd_last_i  = (b == beats - 1);
      rd_data_i  = mem_beat(beat_addr);
      @(negedge clk_i);
      rd_valid_i = 1'b0;
      rd_last_i  = 1'b0;
      rd_data_i  = {next_random(), next_random()};
    end
    waited = 0;
    while (!fetch_valid_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!fetch_valid_o) begin
      $display("Timeout: no fetch response for address %h", addr);
      hung = 1'b1;
      return;
    end
    if (waited != 0) begin
      errors++;
      $display("Fetch response for address %h came %0d cycles late", addr, waited);
    end
    compare_instr("fetch_data_o", fetch_data_o, exp_word);
    if (bypass) begin
      bypasses++;
    end else begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
      misses++;
    end
    @(negedge clk_i);
    compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    compare_bit("fetch_ready_o", fetch_ready_o, 1'b1);
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("test %0s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    logic [31:0]             r;
    icache_pkg::fetch_addr_t addr_a;
    icache_pkg::fetch_addr_t addr_b;
    icache_pkg::fetch_addr_t addr_c;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    fetch_nc_i   = 1'b0;
    en_i         = 1'b1;
    flush_i      = 1'b0;
    rd_gnt_i     = 1'b0;
    rd_valid_i   = 1'b0;
    rd_last_i    = 1'b0;
    rd_data_i    = '0;
    rng_state    = 32'h4ef646d5;
    checks       = 0;
    errors       = 0;
    hits         = 0;
    misses       = 0;
    bypasses     = 0;
    tests_done   = 0;
    test_errors  = 0;
    hung         = 1'b0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
    end
    addr_a = {22'h00123, 6'd5, 2'd1, 2'b00};
    addr_b = {22'h00456, 6'd5, 2'd2, 2'b00};
    addr_c = {22'h00789, 6'd9, 2'd0, 2'b00};

    // Four cycles of reset
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    compare_bit("fetch_ready_o", fetch_ready_o, 1'b1);
    compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    compare_bit("miss_o", miss_o, 1'b0);
    compare_bit("rd_req_o", rd_req_o, 1'b0);
    do_fetch(addr_a, 1'b0, 1'b1);
    finish_test("reset");

    // Fill, hit other words, then evict with a conflicting tag
    do_fetch(addr_a, 1'b0, 1'b1);
    do_fetch(addr_a + 32'd8, 1'b0, 1'b1);
    do_fetch(addr_b, 1'b0, 1'b1);
    do_fetch(addr_a, 1'b0, 1'b1);
    finish_test("miss_hit_conflict");

    // Bypass leaves the arrays alone
    do_fetch(addr_c, 1'b1, 1'b1);
    do_fetch(addr_c + 32'd4, 1'b1, 1'b1);
    do_fetch(addr_c, 1'b0, 1'b1);
    do_fetch(addr_c + 32'd12, 1'b0, 1'b0);
    do_fetch(addr_c + 32'd12, 1'b0, 1'b1);
    finish_test("bypass");

    do_flush();
    do_fetch(addr_a, 1'b0, 1'b1);
    do_fetch(addr_c, 1'b0, 1'b1);
    finish_test("flush");

    // Random mix with random bus delays
    for (int n = 0; n < 300; n++) begin
      if (hung) break;
      r = next_random();
      if (r[3:0] == 4'd0) begin
        do_flush();
      end else begin
        do_fetch(random_addr(), (r[6:4] == 3'd0), (r[10:8] != 3'd0));
      end
    end
    finish_test("random");

    $display("Summary: %0d tests, %0d checks, %0d errors, %0d hits, %0d misses, %0d bypasses",
             tests_done, checks, errors, hits, misses, bypasses);
    if (errors == 0 && !hung) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/rd_bus_pkg.sv
rtl/icache_lookup.sv
rtl/refill_request.sv
rtl/burst_assembler.sv
rtl/icache_refill_top.sv
bench/tb_icache_refill.sv
